// File: src/ldst_pkg.sv
package ldst_pkg;

	// ============================================================
	// widths and constants
	// ============================================================
	localparam int NUM_REGS = 16;
	localparam int FETCH_DEPTH = 2;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr;
	typedef logic [3:0]  reg_num;
	typedef logic [15:0] reg_list;

	typedef enum logic [1:0] {
		LDST_BYTE,
		LDST_HALF,
		LDST_WORD
	} ldst_size;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_XFER,
		ST_WB
	} ldst_state;

	// ============================================================
	// command, bus and register write bundles
	// ============================================================
	typedef struct packed {
		logic     load;
		ldst_size size;
		logic     sign_extend;
		logic     pre_indexed;
		logic     increment;
		logic     writeback;
		logic     block;
		reg_num   base_reg;
		reg_num   rd;
		reg_list  regs;
		word      offset;
	} ldst_cmd;

	typedef struct packed {
		ptr         addr;
		logic [3:0] be;
		word        wdata;
		logic       write;
		logic       start;
	} mem_req;

	typedef struct packed {
		logic ready;
		word  rdata;
	} mem_rsp;

	typedef struct packed {
		logic   en;
		reg_num num;
		word    data;
	} reg_wr;

endpackage

// File: src/ldst_pop.sv
`timescale 1ns/1ps

module ldst_pop (
	input  ldst_pkg::reg_list regs,
	output logic              valid,
	output ldst_pkg::reg_num  pop_lower,
	output ldst_pkg::reg_num  pop_upper,
	output ldst_pkg::reg_list next_lower,
	output ldst_pkg::reg_list next_upper
);
	import ldst_pkg::*;

	assign valid = |regs;

	// lowest set bit, scanning down so the last hit wins
	always_comb begin
		pop_lower = '0;
		for (int i = $bits(regs) - 1; i >= 0; i--) begin
			if (regs[i])
				pop_lower = reg_num'(i);
		end
	end

	// highest set bit
	always_comb begin
		pop_upper = '0;
		for (int i = 0; i < $bits(regs); i++) begin
			if (regs[i])
				pop_upper = reg_num'(i);
		end
	end

	// x & (x - 1) drops the lowest one
	assign next_lower = regs & (regs - reg_list'(1));

	always_comb begin
		next_upper = regs;
		next_upper[pop_upper] = 1'b0;
	end

endmodule

// File: src/ldst_sizes.sv
`timescale 1ns/1ps

module ldst_sizes (
	input  ldst_pkg::ldst_size size,
	input  logic               sign_extend,
	input  logic [1:0]         byte_off,
	input  ldst_pkg::word      store_data,
	input  ldst_pkg::word      rdata,
	output logic [3:0]         be,
	output ldst_pkg::word      wdata,
	output ldst_pkg::word      load_data
);
	import ldst_pkg::*;

	logic [4:0] shift;
	word        shifted;

	// store side: enables and lane replication
	always_comb begin
		case (size)
			LDST_BYTE: begin
				be = 4'b0001 << byte_off;
				wdata = {4{store_data[7:0]}};
				shift = {byte_off, 3'b000};
			end
			LDST_HALF: begin
				be = byte_off[1] ? 4'b1100 : 4'b0011;
				wdata = {2{store_data[15:0]}};
				shift = {byte_off[1], 4'b0000};
			end
			default: begin
				be = 4'b1111;
				wdata = store_data;
				shift = '0;
			end
		endcase
	end

	assign shifted = rdata >> shift;

	// load side: move the lane down, then extend
	always_comb begin
		case (size)
			LDST_BYTE:
				load_data = {{24{sign_extend & shifted[7]}}, shifted[7:0]};
			LDST_HALF:
				load_data = {{16{sign_extend & shifted[15]}}, shifted[15:0]};
			default:
				load_data = shifted;
		endcase
	end

endmodule

// File: src/ldst_control.sv
`timescale 1ns/1ps

module ldst_control (
	input  logic              clk,
	input  logic              rst_n,
	input  ldst_pkg::ldst_cmd cmd,
	input  logic              cmd_issue,
	output logic              busy,
	output ldst_pkg::mem_req  req,
	input  ldst_pkg::mem_rsp  rsp,
	output ldst_pkg::reg_num  rd_num_a,
	output ldst_pkg::reg_num  rd_num_b,
	input  ldst_pkg::word     rd_data_a,
	input  ldst_pkg::word     rd_data_b,
	output ldst_pkg::reg_wr   load_wr
);
	import ldst_pkg::*;

	ldst_state  state;
	ldst_cmd    cmd_q;
	reg_list    mem_regs, next_lower, next_upper;
	reg_num     pop_lower, pop_upper, cur_reg;
	logic       pop_valid, accept, has_first, more, start_q;
	word        base_q, addr_q, new_base, step, load_data, wdata;
	logic [3:0] be;
	ldst_size   xfer_size;
	logic [4:0] reg_count;

	ldst_pop pop (
		.regs(mem_regs),
		.valid(pop_valid),
		.pop_lower(pop_lower),
		.pop_upper(pop_upper),
		.next_lower(next_lower),
		.next_upper(next_upper)
	);

	// block transfers always move whole words
	assign xfer_size = cmd_q.block ? LDST_WORD : cmd_q.size;

	ldst_sizes sizes (
		.size(xfer_size),
		.sign_extend(cmd_q.sign_extend),
		.byte_off(addr_q[1:0]),
		.store_data(rd_data_b),
		.rdata(rsp.rdata),
		.be(be),
		.wdata(wdata),
		.load_data(load_data)
	);

	assign accept = state == ST_IDLE && cmd_issue && !busy;
	assign cur_reg = !cmd_q.block ? cmd_q.rd : cmd_q.increment ? pop_lower : pop_upper;
	assign has_first = !cmd_q.block || pop_valid;
	assign more = cmd_q.block && (cmd_q.increment ? |next_lower : |next_upper);

	assign rd_num_a = cmd_q.base_reg;
	assign rd_num_b = cur_reg;

	assign reg_count = 5'($countones(cmd_q.regs));
	assign step = {25'd0, reg_count, 2'b00};

	always_comb begin
		if (!cmd_q.block)
			new_base = base_q + cmd_q.offset;
		else if (cmd_q.increment)
			new_base = base_q + step;
		else
			new_base = base_q - step;
	end

	assign req = '{addr: addr_q[31:2], be: be, wdata: wdata, write: !cmd_q.load,
		start: start_q};

	// ============================================================
	// sequencer
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			busy <= 1'b0;
			start_q <= 1'b0;
			load_wr <= '0;
		end else begin
			start_q <= 1'b0;
			load_wr.en <= 1'b0;
			case (state)
				ST_IDLE: begin
					busy <= accept;
					if (accept)
						state <= ST_ADDR;
				end
				ST_ADDR: begin
					if (has_first) begin
						start_q <= 1'b1;
						state <= ST_XFER;
					end else begin
						state <= ST_WB;
					end
				end
				ST_XFER: begin
					if (rsp.ready) begin
						if (cmd_q.load)
							load_wr <= '{en: 1'b1, num: cur_reg, data: load_data};
						if (more)
							start_q <= 1'b1;
						else
							state <= ST_WB;
					end
				end
				default: begin
					if (cmd_q.writeback)
						load_wr <= '{en: 1'b1, num: cmd_q.base_reg, data: new_base};
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// command, base and address copies
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= cmd;
			mem_regs <= cmd.regs;
		end
		if (state == ST_ADDR) begin
			base_q <= rd_data_a;
			addr_q <= cmd_q.pre_indexed ? rd_data_a + cmd_q.offset : rd_data_a;
		end
		if (state == ST_XFER && rsp.ready) begin
			mem_regs <= cmd_q.increment ? next_lower : next_upper;
			addr_q <= cmd_q.increment ? addr_q + 32'd4 : addr_q - 32'd4;
		end
	end

	a_start_in_xfer: assert property (@(posedge clk) disable iff (!rst_n)
		req.start |-> state == ST_XFER);

	a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_issue |-> !busy);

endmodule

// File: src/insn_fetch.sv
`timescale 1ns/1ps

module insn_fetch (
	input  logic             clk,
	input  logic             rst_n,
	input  ldst_pkg::ptr     fetch_pc,
	input  logic             fetch_start,
	output ldst_pkg::mem_req req,
	input  ldst_pkg::mem_rsp rsp,
	output logic             insn_valid,
	output ldst_pkg::word    insn_word,
	output ldst_pkg::ptr     insn_addr,
	input  logic             insn_take
);
	import ldst_pkg::*;

	word  buf_word [FETCH_DEPTH];
	ptr   buf_addr [FETCH_DEPTH];
	logic [$clog2(FETCH_DEPTH)-1:0]   rd_ptr, wr_ptr;
	logic [$clog2(FETCH_DEPTH+1)-1:0] count, count_next;
	ptr   pc_q, addr_q;
	logic running, pending, discard, start_q;
	logic push, pop, can_issue;

	assign push = rsp.ready && !discard;
	assign pop = insn_valid && insn_take;

	always_comb begin
		case ({push, pop})
			2'b10: count_next = count + 1'b1;
			2'b01: count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	// a new access reserves the slot its word will land in
	assign can_issue = running && !fetch_start && (!pending || rsp.ready)
		&& count_next < FETCH_DEPTH;

	assign insn_valid = count != '0;
	assign insn_word = buf_word[rd_ptr];
	assign insn_addr = buf_addr[rd_ptr];

	assign req = '{addr: addr_q, be: 4'b1111, wdata: '0, write: 1'b0, start: start_q};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			pending <= 1'b0;
			discard <= 1'b0;
			start_q <= 1'b0;
			count <= '0;
			rd_ptr <= '0;
			wr_ptr <= '0;
			pc_q <= '0;
		end else begin
			start_q <= 1'b0;
			if (fetch_start) begin
				running <= 1'b1;
				pc_q <= fetch_pc;
				count <= '0;
				rd_ptr <= '0;
				wr_ptr <= '0;
				// a reply still on its way belongs to the old stream
				pending <= pending && !rsp.ready;
				discard <= pending && !rsp.ready;
			end else begin
				count <= count_next;
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= rd_ptr + 1'b1;
				if (rsp.ready) begin
					pending <= 1'b0;
					discard <= 1'b0;
				end
				if (can_issue) begin
					start_q <= 1'b1;
					pending <= 1'b1;
					pc_q <= pc_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (can_issue)
			addr_q <= pc_q;
		if (push && !fetch_start) begin
			buf_word[wr_ptr] <= rsp.rdata;
			buf_addr[wr_ptr] <= addr_q;
		end
	end

	a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
		req.start |=> !req.start until_with rsp.ready);

endmodule

// File: src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic             clk,
	input  logic             rst_n,
	input  ldst_pkg::mem_req ls_req,
	output ldst_pkg::mem_rsp ls_rsp,
	input  ldst_pkg::mem_req if_req,
	output ldst_pkg::mem_rsp if_rsp,
	output ldst_pkg::mem_req bus,
	input  ldst_pkg::mem_rsp bus_rsp
);
	import ldst_pkg::*;

	logic active, owner_ls;
	logic ls_pend, if_pend;
	logic ls_want, if_want, grant_ls, grant_if, sel_ls;

	// a start seen while the bus is taken waits here
	assign ls_want = ls_req.start || ls_pend;
	assign if_want = if_req.start || if_pend;

	assign grant_ls = !active && ls_want;
	assign grant_if = !active && !ls_want && if_want;
	assign sel_ls = active ? owner_ls : ls_want;

	always_comb begin
		bus = sel_ls ? ls_req : if_req;
		bus.start = grant_ls || grant_if;
	end

	assign ls_rsp = '{ready: bus_rsp.ready && active && owner_ls, rdata: bus_rsp.rdata};
	assign if_rsp = '{ready: bus_rsp.ready && active && !owner_ls, rdata: bus_rsp.rdata};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			owner_ls <= 1'b0;
			ls_pend <= 1'b0;
			if_pend <= 1'b0;
		end else begin
			ls_pend <= ls_want && !grant_ls;
			if_pend <= if_want && !grant_if;
			if (grant_ls || grant_if) begin
				active <= 1'b1;
				owner_ls <= grant_ls;
			end else if (bus_rsp.ready) begin
				active <= 1'b0;
			end
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		bus.start |=> !bus.start until_with bus_rsp.ready);

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic             clk,
	input  logic             rst_n,
	input  ldst_pkg::reg_num rd_num_a,
	input  ldst_pkg::reg_num rd_num_b,
	output ldst_pkg::word    rd_data_a,
	output ldst_pkg::word    rd_data_b,
	input  ldst_pkg::reg_wr  load_wr,
	input  ldst_pkg::reg_wr  exec_wr,
	output ldst_pkg::reg_wr  wb
);
	import ldst_pkg::*;

	word  regs [NUM_REGS];
	logic exec_ok;

	assign rd_data_a = regs[rd_num_a];
	assign rd_data_b = regs[rd_num_b];

	// load port beats the execute port on the same register
	assign exec_ok = exec_wr.en && !(load_wr.en && load_wr.num == exec_wr.num);
	assign wb = load_wr.en ? load_wr : exec_wr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			if (exec_ok)
				regs[exec_wr.num] <= exec_wr.data;
			if (load_wr.en)
				regs[load_wr.num] <= load_wr.data;
		end
	end

endmodule

// File: src/ldst_top.sv
`timescale 1ns/1ps

module ldst_top (
	input  logic              clk,
	input  logic              rst_n,
	input  ldst_pkg::ldst_cmd cmd,
	input  logic              cmd_issue,
	output logic              busy,
	input  ldst_pkg::ptr      fetch_pc,
	input  logic              fetch_start,
	output logic              insn_valid,
	output ldst_pkg::word     insn_word,
	output ldst_pkg::ptr      insn_addr,
	input  logic              insn_take,
	input  ldst_pkg::reg_wr   exec_wr,
	output ldst_pkg::mem_req  bus,
	input  ldst_pkg::mem_rsp  bus_rsp,
	output ldst_pkg::reg_wr   wb
);
	import ldst_pkg::*;

	mem_req  ls_req, if_req;
	mem_rsp  ls_rsp, if_rsp;
	reg_num  rd_num_a, rd_num_b;
	word     rd_data_a, rd_data_b;
	reg_wr   load_wr;

	ldst_control control (
		.clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_issue(cmd_issue), .busy(busy),
		.req(ls_req), .rsp(ls_rsp), .rd_num_a(rd_num_a), .rd_num_b(rd_num_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .load_wr(load_wr)
	);

	insn_fetch fetch (
		.clk(clk), .rst_n(rst_n), .fetch_pc(fetch_pc), .fetch_start(fetch_start),
		.req(if_req), .rsp(if_rsp), .insn_valid(insn_valid), .insn_word(insn_word),
		.insn_addr(insn_addr), .insn_take(insn_take)
	);

	mem_arbiter arbiter (
		.clk(clk), .rst_n(rst_n), .ls_req(ls_req), .ls_rsp(ls_rsp),
		.if_req(if_req), .if_rsp(if_rsp), .bus(bus), .bus_rsp(bus_rsp)
	);

	reg_file regs (
		.clk(clk), .rst_n(rst_n), .rd_num_a(rd_num_a), .rd_num_b(rd_num_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.load_wr(load_wr), .exec_wr(exec_wr), .wb(wb)
	);

endmodule

// File: verif/ldst_tb.sv
`timescale 1ns/1ps

module ldst_tb;
	import ldst_pkg::*;

	localparam int NUM_CMDS = 48;
	localparam int FETCH_WORDS = 100;
	localparam int MAX_CYCLES = NUM_CMDS * 17 * 6 + FETCH_WORDS * 6 + 1500;
	localparam ptr FETCH_PC = 30'd12;

	logic    clk, rst_n;
	ldst_cmd cmd;
	logic    cmd_issue, busy;
	ptr      fetch_pc;
	logic    fetch_start, insn_valid, insn_take;
	word     insn_word;
	ptr      insn_addr;
	reg_wr   exec_wr, wb;
	mem_req  bus;
	mem_rsp  bus_rsp;

	// memory as the bus sees it, and as the model predicts it
	word   mem [256];
	word   exp_mem [256];
	word   model_regs [NUM_REGS];
	ptr    acc_addr_q [$];
	logic  acc_write_q [$];
	reg_wr wb_q [$];
	int    test_errs, fetch_errs, tests_passed, tests_failed, fetch_taken, cycles;
	logic  fetch_done;

	ldst_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	// register writes seen on wb at mid cycle
	always @(negedge clk) begin
		if (rst_n && wb.en)
			wb_q.push_back(wb);
	end

	function automatic bit same_word(input word got, input word exp, input string what);
		bit ok;
		ok = got === exp;
		assert (ok) else $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		return ok;
	endfunction

	function automatic bit same_count(input int got, input int exp, input string what);
		bit ok;
		ok = got == exp;
		assert (ok) else $display("ERROR at %0t ns: %0d %s seen where %0d were expected",
			$time, got, what, exp);
		return ok;
	endfunction

	// ============================================================
	// memory model and fetch consumer
	// ============================================================
	task automatic memory_model();
		mem_req r;
		int     lat;
		forever begin
			@(negedge clk);
			if (rst_n && bus.start) begin
				r = bus;
				// low half of memory is the fetch region
				if (r.addr >= 128) begin
					acc_addr_q.push_back(r.addr);
					acc_write_q.push_back(r.write);
				end
				if (r.write) begin
					for (int b = 0; b < 4; b++)
						if (r.be[b])
							mem[r.addr[7:0]][8*b +: 8] = r.wdata[8*b +: 8];
				end
				lat = $urandom_range(4, 1);
				repeat (lat) @(posedge clk);
				#10;
				bus_rsp.ready = 1'b1;
				bus_rsp.rdata = mem[r.addr[7:0]];
				@(posedge clk);
				#10;
				bus_rsp = '0;
			end
		end
	endtask

	task automatic fetch_stream();
		ptr next_addr;
		next_addr = FETCH_PC;
		while (fetch_taken < FETCH_WORDS) begin
			@(negedge clk);
			if (insn_valid && insn_take) begin
				if (!same_word(insn_addr, next_addr, "fetch address"))
					fetch_errs++;
				if (!same_word(insn_word, mem[insn_addr[7:0]], "fetch word"))
					fetch_errs++;
				next_addr++;
				fetch_taken++;
			end
			@(posedge clk);
			#10;
			insn_take = fetch_taken < FETCH_WORDS && $urandom_range(2, 0) == 0;
		end
		fetch_done = 1'b1;
	endtask

	// ============================================================
	// stimulus
	// ============================================================
	task automatic exec_write(input reg_num r, input word d);
		exec_wr = '{en: 1'b1, num: r, data: d};
		@(negedge clk);
		if (!same_word(wb.en, 1'b1, "wb.en for exec write"))
			test_errs++;
		if (!same_word(wb.num, r, "wb.num for exec write"))
			test_errs++;
		if (!same_word(wb.data, d, "wb.data for exec write"))
			test_errs++;
		@(posedge clk);
		#10;
		exec_wr.en = 1'b0;
		model_regs[r] = d;
	endtask

	task automatic run_command(input int n);
		ldst_cmd c;
		word     base, addr, new_base, v;
		ptr      exp_addr [$];
		logic    exp_write [$];
		reg_wr   exp_wb [$];
		int      cnt, lane;
		reg_num  r;

		test_errs = 0;
		c = '0;
		c.load = 1'($urandom_range(1, 0));
		c.block = $urandom_range(4, 0) < 2;
		c.size = ldst_size'($urandom_range(2, 0));
		c.sign_extend = 1'($urandom_range(1, 0));
		c.pre_indexed = 1'($urandom_range(1, 0));
		c.increment = 1'($urandom_range(1, 0));
		c.writeback = 1'($urandom_range(1, 0));
		c.base_reg = reg_num'($urandom);
		c.rd = reg_num'($urandom);
		base = 32'd640 + $urandom_range(255, 0);
		if (c.block) begin
			c.regs = reg_list'($urandom);
			c.offset = word'(($urandom_range(4, 0) - 2) * 4);
			base[1:0] = 2'b00;
		end else begin
			c.offset = word'($urandom_range(127, 0)) - 32'd64;
			if (c.size == LDST_HALF) begin
				base[0] = 1'b0;
				c.offset[0] = 1'b0;
			end else if (c.size == LDST_WORD) begin
				base[1:0] = 2'b00;
				c.offset[1:0] = 2'b00;
			end
		end

		exec_write(reg_num'($urandom), $urandom);
		exec_write(c.base_reg, base);

		// predicted accesses, register writes and memory
		addr = c.pre_indexed ? base + c.offset : base;
		if (!c.block) begin
			exp_addr.push_back(addr[31:2]);
			exp_write.push_back(!c.load);
			lane = addr[1:0];
			v = c.load ? exp_mem[addr[9:2]] : model_regs[c.rd];
			if (c.load) begin
				if (c.size == LDST_BYTE) begin
					v = {24'd0, v[8*lane +: 8]};
					if (c.sign_extend && v[7])
						v = v | 32'hffff_ff00;
				end else if (c.size == LDST_HALF) begin
					v = {16'd0, v[16*addr[1] +: 16]};
					if (c.sign_extend && v[15])
						v = v | 32'hffff_0000;
				end
				exp_wb.push_back(reg_wr'{en: 1'b1, num: c.rd, data: v});
				model_regs[c.rd] = v;
			end else if (c.size == LDST_BYTE) begin
				exp_mem[addr[9:2]][8*lane +: 8] = v[7:0];
			end else if (c.size == LDST_HALF) begin
				exp_mem[addr[9:2]][16*addr[1] +: 16] = v[15:0];
			end else begin
				exp_mem[addr[9:2]] = v;
			end
			new_base = base + c.offset;
		end else begin
			cnt = 0;
			for (int i = 0; i < NUM_REGS; i++) begin
				r = c.increment ? reg_num'(i) : reg_num'(NUM_REGS - 1 - i);
				if (c.regs[r]) begin
					cnt++;
					exp_addr.push_back(addr[31:2]);
					exp_write.push_back(!c.load);
					if (c.load) begin
						exp_wb.push_back(reg_wr'{en: 1'b1, num: r, data: exp_mem[addr[9:2]]});
						model_regs[r] = exp_mem[addr[9:2]];
					end else begin
						exp_mem[addr[9:2]] = model_regs[r];
					end
					addr = c.increment ? addr + 32'd4 : addr - 32'd4;
				end
			end
			new_base = c.increment ? base + 4 * cnt : base - 4 * cnt;
		end
		if (c.writeback) begin
			exp_wb.push_back(reg_wr'{en: 1'b1, num: c.base_reg, data: new_base});
			model_regs[c.base_reg] = new_base;
		end

		acc_addr_q.delete();
		acc_write_q.delete();
		wb_q.delete();
		cmd = c;
		cmd_issue = 1'b1;
		@(posedge clk);
		#10;
		cmd_issue = 1'b0;
		assert (busy) else begin
			$display("busy did not rise after command %0d was issued", n);
			test_errs++;
		end
		while (busy) begin
			@(posedge clk);
			#10;
		end

		if (!same_count(acc_addr_q.size(), exp_addr.size(), "memory accesses"))
			test_errs++;
		else
			foreach (exp_addr[i]) begin
				if (!same_word(acc_addr_q[i], exp_addr[i], "access word address"))
					test_errs++;
				if (!same_word(acc_write_q[i], exp_write[i], "access write flag"))
					test_errs++;
			end
		if (!same_count(wb_q.size(), exp_wb.size(), "register writes"))
			test_errs++;
		else
			foreach (exp_wb[i]) begin
				if (!same_word(wb_q[i].num, exp_wb[i].num, "wb.num"))
					test_errs++;
				if (!same_word(wb_q[i].data, exp_wb[i].data, "wb.data"))
					test_errs++;
			end
		for (int i = 0; i < 256; i++)
			if (!same_word(mem[i], exp_mem[i], $sformatf("memory word %0d", i)))
				test_errs++;

		$display("test %0d %s %s: %s", n, c.block ? "block" : "single",
			c.load ? "load" : "store", test_errs == 0 ? "passed" : "failed");
		if (test_errs == 0)
			tests_passed++;
		else
			tests_failed++;
	endtask

	initial begin
		rst_n = 1'b0;
		cmd = '0;
		cmd_issue = 1'b0;
		fetch_pc = '0;
		fetch_start = 1'b0;
		insn_take = 1'b0;
		exec_wr = '0;
		bus_rsp = '0;
		test_errs = 0;
		fetch_errs = 0;
		tests_passed = 0;
		tests_failed = 0;
		fetch_taken = 0;
		fetch_done = 1'b0;
		void'($urandom(32'haf65));
		for (int i = 0; i < 256; i++) begin
			mem[i] = $urandom;
			exp_mem[i] = mem[i];
		end
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		fork
			memory_model();
		join_none

		repeat (5) @(posedge clk);
		#10;
		rst_n = 1'b1;
		@(negedge clk);
		assert (!busy && !bus.start && !insn_valid && !wb.en) else begin
			$display("outputs were not idle after reset");
			test_errs++;
		end
		$display("test 0 reset: %s", test_errs == 0 ? "passed" : "failed");
		if (test_errs == 0)
			tests_passed++;
		else
			tests_failed++;

		// fetch stream runs alongside every command
		@(posedge clk);
		#10;
		fetch_pc = FETCH_PC;
		fetch_start = 1'b1;
		@(posedge clk);
		#10;
		fetch_start = 1'b0;
		fork
			fetch_stream();
		join_none

		for (int n = 1; n <= NUM_CMDS; n++)
			run_command(n);
		wait (fetch_done);
		$display("test %0d fetch stream of %0d words: %s", NUM_CMDS + 1, fetch_taken,
			fetch_errs == 0 ? "passed" : "failed");
		if (fetch_errs == 0)
			tests_passed++;
		else
			tests_failed++;

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: compile.f
src/ldst_pkg.sv
src/ldst_pop.sv
src/ldst_sizes.sv
src/ldst_control.sv
src/insn_fetch.sv
src/mem_arbiter.sv
src/reg_file.sv
src/ldst_top.sv
verif/ldst_tb.sv
